/* project.f */
+incdir+tb
logic/alu_cfg_pkg.sv
logic/setup_response_filter.sv
logic/sync_fifo.sv
logic/alu_config_assembler.sv
logic/alu_ops_configure_memory.sv
tb/tb_alu_ops_configure.sv

/* Makefile */
# Verilator build and run for the ALU configuration loader testbench

TOP = tb_alu_ops_configure
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ns -f project.f \
		--top-module $(TOP) --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tb/tb_alu_ops_tasks.svh */
// -------------------------------------------------
// Directed tests, reference model and compare tasks
// for the ALU configuration loader testbench.
// Included inside the testbench top module body.
// -------------------------------------------------
`ifndef TB_ALU_OPS_TASKS_SVH
`define TB_ALU_OPS_TASKS_SVH

// -------------------------------------------------
// Compare tasks
// -------------------------------------------------
task automatic compare_config(input string name, input alu_config_payload_t got,
                              input alu_config_payload_t exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic compare_status(input string name, input fifo_status_t got,
                              input fifo_status_t exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

// -------------------------------------------------
// Reference model of the filter and the word rule
// -------------------------------------------------
task automatic model_reset();
    model_fields = '0;
    model_pos    = -1;
endtask

task automatic model_packet(input struct_kind_e kind, input int offset,
                            input logic [31:0] data);
    if ((kind == struct_cu_setup || kind == struct_engine_setup) &&
        offset >= seq_min && offset < seq_min + seq_width) begin
        // Idle until the next word at seq_min
        if (offset == seq_min) begin
            model_pos = 0;
        end else if (model_pos >= 0) begin
            model_pos = model_pos + 1;
        end
        case (model_pos)
            0: model_fields.alu_operation = alu_op_e'(data[3:0]);
            1: begin
                model_fields.alu_mask     = data[3:0];
                model_fields.to.id_module = data[7:4];
                model_fields.to.id_engine = data[11:8];
            end
            2: model_fields.const_mask  = data[3:0];
            3: model_fields.const_value = data;
            4: model_fields.ops_mask    = data[15:0];
            5: begin
                model_fields.to.id_cu     = data[3:0];
                model_fields.to.id_bundle = data[7:4];
                model_fields.to.id_lane   = data[11:8];
                model_fields.to.id_buffer = data[15:12];
            end
            default: ;
        endcase
        if (model_pos == seq_width - 1) begin
            exp_q.push_back(model_fields);
            model_pos = -1;
        end
    end
endtask

// -------------------------------------------------
// Stimulus
// -------------------------------------------------
task automatic send_packet(input struct_kind_e kind, input int offset,
                           input logic [31:0] data);
    memory_packet_t pkt;
    pkt.valid          = 1'b1;
    pkt.payload.kind   = kind;
    pkt.payload.offset = 16'(offset);
    pkt.payload.data   = data;
    @(posedge ap_clk);
    response_in <= pkt;
    model_packet(kind, offset, data);
endtask

task automatic send_idle();
    @(posedge ap_clk);
    response_in <= '0;
endtask

task automatic send_clean_run();
    for (int i = 0; i < seq_width; i++) begin
        run_words[i] = lcg_next();
        send_packet(struct_engine_setup, seq_min + i, run_words[i]);
    end
    send_idle();
endtask

// Waits for every modelled record, then watches for extras
task automatic check_records(input string what);
    int n;
    int waited;
    n      = exp_q.size();
    waited = 0;
    while (got_q.size() < n && waited < 300) begin
        @(posedge ap_clk);
        waited++;
    end
    if (got_q.size() < n) begin
        failure_count++;
        $display("%s: only %0d of %0d records arrived in time", what, got_q.size(), n);
    end
    repeat (40) @(posedge ap_clk);
    if (got_q.size() > n) begin
        failure_count++;
        $display("%s: %0d records arrived, %0d expected", what, got_q.size(), n);
    end
    while (exp_q.size() > 0 && got_q.size() > 0) begin
        compare_config("config_out.payload", got_q.pop_front(), exp_q.pop_front());
    end
    exp_q.delete();
    got_q.delete();
endtask

// -------------------------------------------------
// Directed tests
// -------------------------------------------------
task automatic test_reset_state();
    fifo_status_t idle_status;
    idle_status = '{full: 1'b0, empty: 1'b1, prog_full: 1'b0, valid: 1'b0};
    @(negedge ap_clk);
    compare_bit("config_out.valid", config_out.valid, 1'b0);
    compare_status("response_fifo_status", response_fifo_status, idle_status);
    compare_status("config_fifo_status", config_fifo_status, idle_status);
endtask

task automatic test_single_run();
    @(posedge ap_clk);
    response_rd_en <= 1'b1;
    config_rd_en   <= 1'b1;
    send_clean_run();
    check_records("single run");
endtask

// Same words as the clean run, mixed with packets the filter drops
task automatic test_filtered_run();
    for (int i = 0; i < seq_width; i++) begin
        send_packet(struct_graph_data, seq_min + i, lcg_next());
        send_packet((i % 2 == 1) ? struct_cu_setup : struct_engine_setup,
                    seq_min + i, run_words[i]);
        send_packet(struct_cu_setup, seq_min + seq_width + i, lcg_next());
    end
    send_packet(struct_invalid, seq_min, lcg_next());
    send_idle();
    check_records("filtered run");
endtask

task automatic test_backpressure_runs();
    fifo_status_t held_status;
    held_status = '{full: 1'b0, empty: 1'b0, prog_full: 1'b0, valid: 1'b0};
    @(posedge ap_clk);
    config_rd_en <= 1'b0;
    for (int r = 0; r < 4; r++) begin
        send_clean_run();
    end
    repeat (60) @(posedge ap_clk);
    if (got_q.size() != 0) begin
        failure_count++;
        $display("Records left the output FIFO while config_rd_en was low");
    end
    @(negedge ap_clk);
    compare_status("config_fifo_status", config_fifo_status, held_status);
    @(posedge ap_clk);
    config_rd_en <= 1'b1;
    check_records("held runs");
endtask

task automatic test_restart_run();
    for (int i = 0; i < 3; i++) begin
        send_packet(struct_cu_setup, seq_min + i, lcg_next());
    end
    send_clean_run();
    check_records("restart run");
endtask

`endif

/* tb/tb_alu_ops_configure.sv */
`timescale 1ns/1ns
// -------------------------------------------------
// Testbench for the ALU configuration loader.
// Drives memory responses into the DUT, collects
// config_out records and checks them against a
// model of the word rule. Run through project.f.
// -------------------------------------------------

module tb_alu_ops_configure;

    import alu_cfg_pkg::*;

    // Mirrors the DUT defaults
    localparam int seq_min   = 0;
    localparam int seq_width = 16;

    // Tests take about 500 cycles together
    localparam int timeout_cycles = 4000;

    logic           ap_clk;
    logic           areset_alu_ops_generator;
    memory_packet_t response_in;
    logic           response_rd_en;
    logic           config_rd_en;
    alu_config_t    config_out;
    fifo_status_t   response_fifo_status;
    fifo_status_t   config_fifo_status;

    logic [31:0]         lcg_state;
    int                  cycle_count;
    int                  check_count;
    int                  mismatch_count;
    int                  failure_count;
    alu_config_payload_t got_q[$];
    alu_config_payload_t exp_q[$];
    alu_config_payload_t model_fields;
    int                  model_pos;
    logic [31:0]         run_words [seq_width];

    alu_ops_configure_memory dut0 (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .response_in              (response_in),
        .response_rd_en           (response_rd_en),
        .config_rd_en             (config_rd_en),
        .config_out               (config_out),
        .response_fifo_status     (response_fifo_status),
        .config_fifo_status       (config_fifo_status)
    );

    initial begin
        ap_clk = 1'b0;
    end

    always #10 ap_clk = ~ap_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_counts();
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, failure_count);
    endtask

    `include "tb_alu_ops_tasks.svh"

    // Collect every record leaving the DUT
    always @(negedge ap_clk) begin
        if (!areset_alu_ops_generator && config_out.valid) begin
            got_q.push_back(config_out.payload);
        end
    end

    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            report_counts();
            $display("Test failures found");
            $finish;
        end
    end

    // -------------------------------------------------
    // Test sequence
    // -------------------------------------------------
    initial begin
        lcg_state                = 32'hf45687af;
        cycle_count              = 0;
        check_count              = 0;
        mismatch_count           = 0;
        failure_count            = 0;
        areset_alu_ops_generator = 1'b1;
        response_in              = '0;
        response_rd_en           = 1'b0;
        config_rd_en             = 1'b0;
        model_reset();
        repeat (5) @(posedge ap_clk);
        areset_alu_ops_generator <= 1'b0;
        @(posedge ap_clk);

        test_reset_state();
        test_single_run();
        test_filtered_run();
        test_backpressure_runs();
        test_restart_run();

        report_counts();
        if (mismatch_count + failure_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* logic/alu_ops_configure_memory.sv */
`timescale 1ns/1ns
// -----------------------------------------------
// ALU operation configuration loader for a single
// engine. Filters setup responses into an input
// queue, assembles configuration records and holds
// them in an output queue popped by config_rd_en.
// -----------------------------------------------

module alu_ops_configure_memory #(
    parameter int seq_min     = 0,
    parameter int seq_width   = 16,   // at least 6 so every field has a word
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8
) (
    input  logic                        ap_clk,
    input  logic                        areset_alu_ops_generator,
    input  alu_cfg_pkg::memory_packet_t response_in,
    input  logic                        response_rd_en,
    input  logic                        config_rd_en,
    output alu_cfg_pkg::alu_config_t    config_out,
    output alu_cfg_pkg::fifo_status_t   response_fifo_status,
    output alu_cfg_pkg::fifo_status_t   config_fifo_status
);

    import alu_cfg_pkg::*;

    logic                filter_push;
    packet_payload_t     filter_payload;
    packet_payload_t     response_dout;
    logic                response_pop_en;
    logic                stall;
    logic                assembler_push;
    alu_config_payload_t assembler_payload;
    alu_config_payload_t config_dout;
    logic                config_valid_q;
    alu_config_payload_t config_payload_q;

    setup_response_filter #(
        .seq_min   (seq_min),
        .seq_width (seq_width)
    ) inst_filter (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .response_in              (response_in),
        .push                     (filter_push),
        .push_payload             (filter_payload)
    );

    // -----------------------------------------------
    // Input queue, held while a record completes
    // -----------------------------------------------
    assign response_pop_en = response_rd_en && !stall;

    sync_fifo #(
        .width       ($bits(packet_payload_t)),
        .depth       (fifo_depth),
        .prog_thresh (prog_thresh)
    ) inst_response_fifo (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .push                     (filter_push),
        .din                      (filter_payload),
        .rd_en                    (response_pop_en),
        .dout                     (response_dout),
        .status                   (response_fifo_status)
    );

    alu_config_assembler #(
        .seq_min   (seq_min),
        .seq_width (seq_width)
    ) inst_assembler (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .word_in                  (response_dout),
        .word_valid               (response_fifo_status.valid),
        .out_prog_full            (config_fifo_status.prog_full),
        .stall                    (stall),
        .push                     (assembler_push),
        .push_payload             (assembler_payload)
    );

    // -----------------------------------------------
    // Output queue
    // -----------------------------------------------
    sync_fifo #(
        .width       ($bits(alu_config_payload_t)),
        .depth       (fifo_depth),
        .prog_thresh (prog_thresh)
    ) inst_config_fifo (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .push                     (assembler_push),
        .din                      (assembler_payload),
        .rd_en                    (config_rd_en),
        .dout                     (config_dout),
        .status                   (config_fifo_status)
    );

    // Output register, two cycles after config_rd_en
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            config_valid_q <= 1'b0;
        end else begin
            config_valid_q <= config_fifo_status.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        config_payload_q <= config_dout;
    end

    assign config_out = '{valid: config_valid_q, payload: config_payload_q};

endmodule

/* logic/alu_config_assembler.sv */
`timescale 1ns/1ns
// -----------------------------------------------
// Builds one ALU configuration record from each run
// of seq_width setup words starting at seq_min.
// The record is pushed three cycles after the last
// word of the run is presented on word_in.
// -----------------------------------------------

module alu_config_assembler #(
    parameter int seq_min   = 0,
    parameter int seq_width = 16
) (
    input  logic                             ap_clk,
    input  logic                             areset_alu_ops_generator,
    input  alu_cfg_pkg::packet_payload_t     word_in,
    input  logic                             word_valid,
    input  logic                             out_prog_full,
    output logic                             stall,
    output logic                             push,
    output alu_cfg_pkg::alu_config_payload_t push_payload
);

    import alu_cfg_pkg::*;

    // One-hot positions of the decoded words
    localparam logic [seq_width-1:0] pos_0 = seq_width'(32'd1 << 0);
    localparam logic [seq_width-1:0] pos_1 = seq_width'(32'd1 << 1);
    localparam logic [seq_width-1:0] pos_2 = seq_width'(32'd1 << 2);
    localparam logic [seq_width-1:0] pos_3 = seq_width'(32'd1 << 3);
    localparam logic [seq_width-1:0] pos_4 = seq_width'(32'd1 << 4);
    localparam logic [seq_width-1:0] pos_5 = seq_width'(32'd1 << 5);

    logic [seq_width-1:0] seq;
    logic                 restart;
    logic                 word_valid_q;
    packet_payload_t      word_q;
    logic                 done_q;
    alu_config_payload_t  fields;

    assign restart = (word_in.offset == offset_w'(seq_min));

    // -----------------------------------------------
    // Sequence tracking
    // -----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            seq          <= '0;
            word_valid_q <= 1'b0;
            done_q       <= 1'b0;
            push         <= 1'b0;
        end else begin
            word_valid_q <= word_valid;
            // Single pulse per completed run
            done_q <= seq[seq_width-1] && !done_q;
            push   <= done_q;
            if (word_valid) begin
                if (restart) begin
                    seq <= pos_0;
                end else begin
                    seq <= seq << 1;
                end
            end else if (done_q) begin
                seq <= '0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        word_q <= word_in;
    end

    // -----------------------------------------------
    // Field decode
    // -----------------------------------------------

    // Untouched fields keep the value of the previous record
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            fields <= '0;
        end else if (word_valid_q) begin
            case (seq)
                pos_0: begin
                    fields.alu_operation <= alu_op_e'(word_q.data[3:0]);
                end
                pos_1: begin
                    fields.alu_mask     <= word_q.data[num_fields-1:0];
                    fields.to.id_module <= word_q.data[7:4];
                    fields.to.id_engine <= word_q.data[11:8];
                end
                pos_2: begin
                    fields.const_mask <= word_q.data[num_fields-1:0];
                end
                pos_3: begin
                    fields.const_value <= word_q.data;
                end
                pos_4: begin
                    fields.ops_mask <= word_q.data[num_fields*num_fields-1:0];
                end
                pos_5: begin
                    fields.to.id_cu     <= word_q.data[3:0];
                    fields.to.id_bundle <= word_q.data[7:4];
                    fields.to.id_lane   <= word_q.data[11:8];
                    fields.to.id_buffer <= word_q.data[15:12];
                end
                // Words 6 and above carry nothing here
                default: ;
            endcase
        end
    end

    // -----------------------------------------------
    // Output
    // -----------------------------------------------

    // Snapshot before a restarted run can overwrite word 0
    always_ff @(posedge ap_clk) begin
        if (done_q) begin
            push_payload <= fields;
        end
    end

    assign stall = done_q || out_prog_full;

endmodule

/* logic/sync_fifo.sv */
`timescale 1ns/1ns
// -----------------------------------------------
// Synchronous FIFO with registered read data.
// A pop (rd_en while not empty) presents dout and
// status.valid on the next cycle. Pushes into a
// full FIFO are dropped.
// -----------------------------------------------

module sync_fifo #(
    parameter int width       = 52,
    parameter int depth       = 16,
    parameter int prog_thresh = 8
) (
    input  logic                      ap_clk,
    input  logic                      areset_alu_ops_generator,
    input  logic                      push,
    input  logic [width-1:0]          din,
    input  logic                      rd_en,
    output logic [width-1:0]          dout,
    output alu_cfg_pkg::fifo_status_t status
);

    localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;

    logic [width-1:0]  mem [depth];
    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   count;
    logic              is_full;
    logic              is_empty;
    logic              is_prog_full;
    logic              wr_ok;
    logic              rd_ok;
    logic              valid_q;

    // Wrap at depth so non power of two sizes work
    function automatic logic [addr_w-1:0] next_ptr(input logic [addr_w-1:0] ptr);
        logic [addr_w-1:0] nxt;
        if (ptr == addr_w'(depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign is_full      = (count == (addr_w + 1)'(depth));
    assign is_empty     = (count == '0);
    assign is_prog_full = (count >= (addr_w + 1)'(prog_thresh));
    assign wr_ok        = push && !is_full;
    assign rd_ok        = rd_en && !is_empty;

    // -----------------------------------------------
    // Pointers and occupancy
    // -----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    assign status = '{full: is_full, empty: is_empty, prog_full: is_prog_full, valid: valid_q};

endmodule

/* logic/setup_response_filter.sv */
`timescale 1ns/1ns
// -----------------------------------------------
// Input stage of the ALU configuration loader.
// Registers each memory response and pushes it to
// the input queue one cycle later when it is a
// setup packet inside this engine's word window.
// -----------------------------------------------

module setup_response_filter #(
    parameter int seq_min   = 0,
    parameter int seq_width = 16
) (
    input  logic                         ap_clk,
    input  logic                         areset_alu_ops_generator,
    input  alu_cfg_pkg::memory_packet_t  response_in,
    output logic                         push,
    output alu_cfg_pkg::packet_payload_t push_payload
);

    import alu_cfg_pkg::*;

    logic                in_valid_q;
    packet_payload_t     in_payload_q;
    logic                kind_ok;
    logic [offset_w-1:0] window_pos;
    logic                in_window;

    // -----------------------------------------------
    // Input register
    // -----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= response_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_payload_q <= response_in.payload;
    end

    // -----------------------------------------------
    // Filter
    // -----------------------------------------------

    // Only CU and engine setup packets carry configuration
    assign kind_ok = (in_payload_q.kind == struct_cu_setup) ||
                     (in_payload_q.kind == struct_engine_setup);

    // Offsets below seq_min wrap to large values and fall outside
    assign window_pos = in_payload_q.offset - offset_w'(seq_min);
    assign in_window  = (window_pos < offset_w'(seq_width));

    assign push         = in_valid_q && kind_ok && in_window;
    assign push_payload = in_payload_q;

endmodule

/* logic/alu_cfg_pkg.sv */
// -----------------------------------------------
// Widths, encodings and packed types shared by the
// ALU configuration loader and its testbench.
// Import with alu_cfg_pkg::* inside a module body,
// or use scoped names in port lists.
// -----------------------------------------------

package alu_cfg_pkg;

    // -----------------------------------------------
    // Widths
    // -----------------------------------------------
    localparam int data_w     = 32;
    localparam int offset_w   = 16;
    localparam int num_fields = 4;

    // -----------------------------------------------
    // Encodings
    // -----------------------------------------------

    // Buffer class carried by each memory response
    typedef enum logic [3:0] {
        struct_invalid      = 4'd0,
        struct_cu_setup     = 4'd1,
        struct_engine_setup = 4'd2,
        struct_graph_data   = 4'd3
    } struct_kind_e;

    typedef enum logic [3:0] {
        alu_nop = 4'd0,
        alu_add = 4'd1,
        alu_sub = 4'd2,
        alu_mul = 4'd3,
        alu_acc = 4'd4,
        alu_div = 4'd5,
        alu_gt  = 4'd6,
        alu_lt  = 4'd7,
        alu_eq  = 4'd8,
        alu_ne  = 4'd9
    } alu_op_e;

    // -----------------------------------------------
    // Packets
    // -----------------------------------------------
    typedef struct packed {
        struct_kind_e        kind;
        logic [offset_w-1:0] offset;   // word index, not a byte address
        logic [data_w-1:0]   data;
    } packet_payload_t;

    typedef struct packed {
        logic            valid;
        packet_payload_t payload;
    } memory_packet_t;

    // -----------------------------------------------
    // ALU configuration record
    // -----------------------------------------------

    // Destination of the configured engine
    typedef struct packed {
        logic [3:0] id_cu;
        logic [3:0] id_bundle;
        logic [3:0] id_lane;
        logic [3:0] id_buffer;
        logic [3:0] id_engine;
        logic [3:0] id_module;
    } route_to_t;

    typedef struct packed {
        alu_op_e                            alu_operation;
        logic [num_fields-1:0]              alu_mask;
        logic [num_fields-1:0]              const_mask;
        logic [data_w-1:0]                  const_value;
        logic [num_fields*num_fields-1:0]   ops_mask;
        route_to_t                          to;
    } alu_config_payload_t;

    typedef struct packed {
        logic                valid;
        alu_config_payload_t payload;
    } alu_config_t;

    // FIFO flags, valid marks dout one cycle after a pop
    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
        logic valid;
    } fifo_status_t;

endpackage
